// File: src/rv_isa_pkg.sv
/* rv64 instruction set definitions */
package rv_isa_pkg;

    localparam int unsigned xlen = 64;

    typedef logic [4:0] reg_idx_t;

    // major opcodes of the integer computational groups
    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_imm_32 = 7'b0011011,
        op        = 7'b0110011,
        op_32     = 7'b0111011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_t;

    // all eight encodings are named, sub/sra come from bit 30
    typedef enum logic [2:0] {
        f3_add  = 3'b000,
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } funct3_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        funct3_t    funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        funct3_t     funct3;
        reg_idx_t    rd;
        opcode_t     opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        opcode_t     opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } instr_t;

    // not a legal opcode, decodes to a bubble
    localparam logic [31:0] nop_word = 32'h0000_0000;

endpackage

// File: src/core_pkg.sv
/* core bus and pipeline types */
package core_pkg;

    localparam int unsigned wb_adr_w = rv_isa_pkg::xlen;
    localparam int unsigned wb_dat_w = 32;

    // wishbone classic, read only
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic [wb_adr_w-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [wb_dat_w-1:0] dat;
    } wb_rsp_t;

    // decode to execute
    typedef struct packed {
        logic                          valid;
        logic [rv_isa_pkg::xlen-1:0]   pc;
        rv_isa_pkg::instr_t            instr;
        logic [rv_isa_pkg::xlen-1:0]   rs1_val;
        logic [rv_isa_pkg::xlen-1:0]   rs2_val;
        logic [rv_isa_pkg::xlen-1:0]   imm;
    } dec_ex_t;

    // writeback register, also the retire record
    typedef struct packed {
        logic                          valid;
        logic [rv_isa_pkg::xlen-1:0]   pc;
        rv_isa_pkg::reg_idx_t          rd;
        logic [rv_isa_pkg::xlen-1:0]   value;
    } retire_t;

endpackage

// File: src/fetch_unit.sv
/* instruction fetch */
module fetch_unit #(
    parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                        c_clk,
    input  logic                        c_rst_n,
    input  core_pkg::wb_rsp_t           ibus_i,
    output core_pkg::wb_req_t           ibus_o,
    output logic                        fd_valid_o,
    output logic [rv_isa_pkg::xlen-1:0] fd_pc_o,
    output rv_isa_pkg::instr_t          fd_instr_o
);
    import rv_isa_pkg::*;

    logic            req_q;
    logic [xlen-1:0] pc_q;
    logic            take;

    // request is held until ack, then the next one starts at once
    assign ibus_o.cyc = req_q;
    assign ibus_o.stb = req_q;
    assign ibus_o.adr = pc_q;

    assign take = req_q && ibus_i.ack;

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            req_q      <= 1'b0;
            pc_q       <= reset_pc;
            fd_valid_o <= 1'b0;
        end else begin
            req_q      <= 1'b1;
            fd_valid_o <= take;
            if (take) begin
                pc_q <= pc_q + xlen'(4);
            end
        end
    end

    // fetch/decode payload
    always_ff @(posedge c_clk) begin
        if (take) begin
            fd_pc_o    <= pc_q;
            fd_instr_o <= ibus_i.dat;
        end
    end

endmodule

// File: src/decode_stage.sv
/* instruction decode */
module decode_stage (
    input  logic                        c_clk,
    input  logic                        c_rst_n,
    input  logic                        fd_valid_i,
    input  logic [rv_isa_pkg::xlen-1:0] fd_pc_i,
    input  rv_isa_pkg::instr_t          fd_instr_i,
    input  logic [rv_isa_pkg::xlen-1:0] rs1_data_i,
    input  logic [rv_isa_pkg::xlen-1:0] rs2_data_i,
    output rv_isa_pkg::reg_idx_t        rs1_addr_o,
    output rv_isa_pkg::reg_idx_t        rs2_addr_o,
    output core_pkg::dec_ex_t           dx_o
);
    import rv_isa_pkg::*;

    logic            kept;
    logic [xlen-1:0] imm;
    logic            valid_q;
    logic [xlen-1:0] pc_q;
    instr_t          instr_q;
    logic [xlen-1:0] rs1_q;
    logic [xlen-1:0] rs2_q;
    logic [xlen-1:0] imm_q;

    // source fields sit at the same place in every format
    assign rs1_addr_o = fd_instr_i.r.rs1;
    assign rs2_addr_o = fd_instr_i.r.rs2;

    // opcode filter and immediate mux
    always_comb begin
        kept = 1'b0;
        imm  = '0;
        case (fd_instr_i.r.opcode)
            op_imm, op_imm_32: begin
                kept = 1'b1;
                imm  = {{(xlen-12){fd_instr_i.i.imm[11]}}, fd_instr_i.i.imm};
            end
            op_lui, op_auipc: begin
                kept = 1'b1;
                imm  = {{(xlen-32){fd_instr_i.u.imm[19]}}, fd_instr_i.u.imm, 12'b0};
            end
            op, op_32: begin
                kept = 1'b1;
            end
            default: begin
                kept = 1'b0;
            end
        endcase
    end

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fd_valid_i && kept;
        end
    end

    always_ff @(posedge c_clk) begin
        if (fd_valid_i) begin
            pc_q    <= fd_pc_i;
            instr_q <= fd_instr_i;
            rs1_q   <= rs1_data_i;
            rs2_q   <= rs2_data_i;
            imm_q   <= imm;
        end
    end

    assign dx_o = '{valid: valid_q, pc: pc_q, instr: instr_q,
                    rs1_val: rs1_q, rs2_val: rs2_q, imm: imm_q};

endmodule

// File: src/regfile.sv
/* integer register file */
module regfile (
    input  logic                        c_clk,
    input  logic                        c_rst_n,
    input  rv_isa_pkg::reg_idx_t        rs1_addr_i,
    input  rv_isa_pkg::reg_idx_t        rs2_addr_i,
    input  core_pkg::retire_t           wr_i,
    output logic [rv_isa_pkg::xlen-1:0] rs1_data_o,
    output logic [rv_isa_pkg::xlen-1:0] rs2_data_o
);
    import rv_isa_pkg::*;

    logic [xlen-1:0] regs_q [1:31];

    // x0 is hardwired, a same-cycle write passes straight through
    function automatic logic [xlen-1:0] read_port(input reg_idx_t addr);
        logic [xlen-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_i.valid && wr_i.rd == addr) begin
            data = wr_i.value;
        end else begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            for (int k = 1; k < 32; k++) begin
                regs_q[k] <= '0;
            end
        end else if (wr_i.valid && wr_i.rd != '0) begin
            regs_q[wr_i.rd] <= wr_i.value;
        end
    end

endmodule

// File: src/alu.sv
/* integer alu */
module alu (
    input  logic [rv_isa_pkg::xlen-1:0] a_i,
    input  logic [rv_isa_pkg::xlen-1:0] b_i,
    input  rv_isa_pkg::funct3_t         funct3_i,
    input  logic                        alt_i,
    input  logic                        word_i,
    input  logic                        use_alt_i,
    output logic [rv_isa_pkg::xlen-1:0] result_o
);
    import rv_isa_pkg::*;

    logic                   alt;
    logic [5:0]             shamt;
    logic [xlen-1:0]        sh_src;
    logic [xlen-1:0]        srl_res;
    logic signed [xlen-1:0] sra_res;
    logic [xlen-1:0]        res;

    assign alt = alt_i && use_alt_i;

    // word shifts use only five bits of the amount
    assign shamt = word_i ? {1'b0, b_i[4:0]} : b_i[5:0];

    // word right shifts start from the low word, extended by kind
    assign sh_src = word_i ? {{(xlen-32){alt && a_i[31]}}, a_i[31:0]} : a_i;

    assign srl_res = sh_src >> shamt;
    assign sra_res = $signed(sh_src) >>> shamt;

    always_comb begin
        case (funct3_i)
            f3_add: begin
                res = alt ? a_i - b_i : a_i + b_i;
            end
            f3_sll: begin
                res = a_i << shamt;
            end
            f3_slt: begin
                res = {{(xlen-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            end
            f3_sltu: begin
                res = {{(xlen-1){1'b0}}, a_i < b_i};
            end
            f3_xor: begin
                res = a_i ^ b_i;
            end
            f3_sr: begin
                res = alt ? sra_res : srl_res;
            end
            f3_or: begin
                res = a_i | b_i;
            end
            default: begin
                res = a_i & b_i;
            end
        endcase
    end

    // W forms sign-extend bit 31
    assign result_o = word_i ? {{(xlen-32){res[31]}}, res[31:0]} : res;

endmodule

// File: src/execute_stage.sv
/* execute and writeback register */
module execute_stage (
    input  logic              c_clk,
    input  logic              c_rst_n,
    input  core_pkg::dec_ex_t dx_i,
    output core_pkg::retire_t wb_o
);
    import rv_isa_pkg::*;

    opcode_t         opc;
    logic            is_imm;
    logic            is_u;
    logic            is_word;
    logic            use_alt;
    funct3_t         funct3;
    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_res;
    logic            wb_valid_q;
    logic [xlen-1:0] wb_pc_q;
    reg_idx_t        wb_rd_q;
    logic [xlen-1:0] wb_val_q;

    assign opc     = dx_i.instr.r.opcode;
    assign is_imm  = opc inside {op_imm, op_imm_32};
    assign is_u    = opc inside {op_lui, op_auipc};
    assign is_word = opc inside {op_imm_32, op_32};

    // lui and auipc carry immediate bits in the funct3 field
    assign funct3  = is_u ? f3_add : dx_i.instr.r.funct3;
    assign use_alt = !is_u && !(is_imm && funct3 == f3_add);

    // bypass from the writeback register
    assign fwd_rs1 = wb_o.valid && wb_o.rd != '0 && wb_o.rd == dx_i.instr.r.rs1;
    assign fwd_rs2 = wb_o.valid && wb_o.rd != '0 && wb_o.rd == dx_i.instr.r.rs2;
    assign rs1_val = fwd_rs1 ? wb_o.value : dx_i.rs1_val;
    assign rs2_val = fwd_rs2 ? wb_o.value : dx_i.rs2_val;

    assign op_a = (opc == op_auipc) ? dx_i.pc : (opc == op_lui) ? '0 : rs1_val;
    assign op_b = (is_imm || is_u) ? dx_i.imm : rs2_val;

    alu u_alu (
        .a_i       (op_a                    ),
        .b_i       (op_b                    ),
        .funct3_i  (funct3                  ),
        .alt_i     (dx_i.instr.r.funct7[5]  ),
        .word_i    (is_word                 ),
        .use_alt_i (use_alt                 ),
        .result_o  (alu_res                 )
    );

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= dx_i.valid;
        end
    end

    always_ff @(posedge c_clk) begin
        if (dx_i.valid) begin
            wb_pc_q  <= dx_i.pc;
            wb_rd_q  <= dx_i.instr.r.rd;
            wb_val_q <= (dx_i.instr.r.rd == '0) ? '0 : alu_res;
        end
    end

    assign wb_o = '{valid: wb_valid_q, pc: wb_pc_q, rd: wb_rd_q, value: wb_val_q};

endmodule

// File: src/rv_core_top.sv
/* rv64 integer core */
module rv_core_top #(
    parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic              c_clk,
    input  logic              c_rst_n,
    input  core_pkg::wb_rsp_t ibus_i,
    output core_pkg::wb_req_t ibus_o,
    output core_pkg::retire_t retire_o
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic            fd_valid;
    logic [xlen-1:0] fd_pc;
    instr_t          fd_instr;
    reg_idx_t        rs1_addr;
    reg_idx_t        rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    dec_ex_t         dx;
    retire_t         wb;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) u_fetch_unit (
        .c_clk      (c_clk      ),
        .c_rst_n    (c_rst_n    ),
        .ibus_i     (ibus_i     ),
        .ibus_o     (ibus_o     ),
        .fd_valid_o (fd_valid   ),
        .fd_pc_o    (fd_pc      ),
        .fd_instr_o (fd_instr   )
    );

    decode_stage u_decode_stage (
        .c_clk      (c_clk      ),
        .c_rst_n    (c_rst_n    ),
        .fd_valid_i (fd_valid   ),
        .fd_pc_i    (fd_pc      ),
        .fd_instr_i (fd_instr   ),
        .rs1_data_i (rs1_data   ),
        .rs2_data_i (rs2_data   ),
        .rs1_addr_o (rs1_addr   ),
        .rs2_addr_o (rs2_addr   ),
        .dx_o       (dx         )
    );

    // written from the writeback register
    regfile u_regfile (
        .c_clk      (c_clk      ),
        .c_rst_n    (c_rst_n    ),
        .rs1_addr_i (rs1_addr   ),
        .rs2_addr_i (rs2_addr   ),
        .wr_i       (wb         ),
        .rs1_data_o (rs1_data   ),
        .rs2_data_o (rs2_data   )
    );

    execute_stage u_execute_stage (
        .c_clk      (c_clk      ),
        .c_rst_n    (c_rst_n    ),
        .dx_i       (dx         ),
        .wb_o       (wb         )
    );

    assign retire_o = wb;

endmodule

// File: sim/rv_core_assertions.sv
/* fetch bus and retire port checks */
module rv_core_assertions (
    input logic              c_clk,
    input logic              c_rst_n,
    input core_pkg::wb_req_t ibus_o,
    input core_pkg::wb_rsp_t ibus_i,
    input core_pkg::retire_t retire_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // number of failed assertions
    int unsigned fail_cnt = 0;

    // strobe only inside a cycle
    stb_within_cyc: assert property (
        @(posedge c_clk) disable iff (!c_rst_n)
        ibus_o.stb |-> ibus_o.cyc
    ) else begin
        fail_cnt++;
        $error("stb high without cyc");
    end

    // request held until the slave acks
    req_held_until_ack: assert property (
        @(posedge c_clk) disable iff (!c_rst_n)
        (ibus_o.stb && !ibus_i.ack) |=> (ibus_o.stb && ibus_o.cyc && $stable(ibus_o.adr))
    ) else begin
        fail_cnt++;
        $error("request changed before ack");
    end

    // sampled mid-cycle, after the first reset edge has cleared the flops
    no_retire_in_reset: assert property (
        @(negedge c_clk)
        !c_rst_n |-> !retire_o.valid
    ) else begin
        fail_cnt++;
        $error("retire valid while reset is held");
    end

endmodule

// File: sim/tb_rv_core.sv
/* rv64 core testbench */
module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import core_pkg::*;

    typedef struct {
        string       name;
        logic [31:0] word;
        logic        retires;
        logic        fast;
        logic [4:0]  rd;
        logic [63:0] value;
    } entry_t;

    localparam int n_entries    = 39;
    localparam int limit_cycles = n_entries * 6 + 50;

    logic    c_clk = 1'b0;
    logic    c_rst_n = 1'b0;
    wb_req_t ibus_o;
    wb_rsp_t ibus_i = '0;
    retire_t retire_o;

    entry_t  prog [n_entries];
    integer  seed = 32'h2979;
    int      wait_cnt = 0;
    logic    pending = 1'b0;

    rv_core_top #(
        .reset_pc (64'h0)
    ) u_dut (
        .c_clk    (c_clk   ),
        .c_rst_n  (c_rst_n ),
        .ibus_i   (ibus_i  ),
        .ibus_o   (ibus_o  ),
        .retire_o (retire_o)
    );

    bind rv_core_top rv_core_assertions u_assertions (.*);

    always #2 c_clk = ~c_clk;

    function automatic logic [31:0] r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_word(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    task automatic put(int idx, string name, logic [31:0] word, logic [4:0] rd,
                       logic [63:0] value);
        prog[idx] = '{name: name, word: word, retires: 1'b1, fast: (idx >= 31),
                      rd: rd, value: value};
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fill_program();
        put(0,  "addi",  i_word(12'd5, 0, f3_add, 1, op_imm), 1, 64'h5);
        put(1,  "addi neg", i_word(12'hffd, 0, f3_add, 2, op_imm), 2, 64'hffff_ffff_ffff_fffd);
        put(2,  "slti",  i_word(12'd1, 2, f3_slt, 3, op_imm), 3, 64'h1);
        put(3,  "sltiu", i_word(12'd1, 2, f3_sltu, 4, op_imm), 4, 64'h0);
        put(4,  "xori",  i_word(12'h0ff, 1, f3_xor, 5, op_imm), 5, 64'hfa);
        put(5,  "ori",   i_word(12'h030, 1, f3_or, 6, op_imm), 6, 64'h35);
        put(6,  "andi",  i_word(12'h0f0, 2, f3_and, 7, op_imm), 7, 64'hf0);
        put(7,  "slli",  i_word(12'h028, 1, f3_sll, 8, op_imm), 8, 64'h0000_0500_0000_0000);
        put(8,  "srli",  i_word(12'h03c, 2, f3_sr, 9, op_imm), 9, 64'hf);
        put(9,  "srai",  i_word(12'h401, 2, f3_sr, 10, op_imm), 10, 64'hffff_ffff_ffff_fffe);
        put(10, "lui",   u_word(20'h80000, 11, op_lui), 11, 64'hffff_ffff_8000_0000);
        put(11, "auipc", u_word(20'h00001, 12, op_auipc), 12, 64'h102c);
        put(12, "add",   r_word(7'h00, 2, 1, f3_add, 13, op), 13, 64'h2);
        put(13, "sub",   r_word(7'h20, 2, 1, f3_add, 14, op), 14, 64'h8);
        put(14, "sll",   r_word(7'h00, 12, 1, f3_sll, 15, op), 15, 64'h0000_5000_0000_0000);
        put(15, "slt",   r_word(7'h00, 1, 2, f3_slt, 16, op), 16, 64'h1);
        put(16, "sltu",  r_word(7'h00, 1, 2, f3_sltu, 17, op), 17, 64'h0);
        put(17, "xor",   r_word(7'h00, 2, 1, f3_xor, 18, op), 18, 64'hffff_ffff_ffff_fff8);
        put(18, "srl",   r_word(7'h00, 1, 2, f3_sr, 19, op), 19, 64'h07ff_ffff_ffff_ffff);
        put(19, "sra",   r_word(7'h20, 1, 2, f3_sr, 20, op), 20, 64'hffff_ffff_ffff_ffff);
        put(20, "or",    r_word(7'h00, 7, 1, f3_or, 21, op), 21, 64'hf5);
        put(21, "and",   r_word(7'h00, 6, 2, f3_and, 22, op), 22, 64'h35);
        put(22, "addiw", i_word(12'hfff, 11, f3_add, 23, op_imm_32), 23, 64'h7fff_ffff);
        put(23, "slliw", i_word(12'h01f, 1, f3_sll, 24, op_imm_32), 24, 64'hffff_ffff_8000_0000);
        put(24, "srliw", i_word(12'h004, 2, f3_sr, 25, op_imm_32), 25, 64'h0fff_ffff);
        put(25, "sraiw", i_word(12'h404, 11, f3_sr, 26, op_imm_32), 26, 64'hffff_ffff_f800_0000);
        put(26, "addw",  r_word(7'h00, 11, 11, f3_add, 27, op_32), 27, 64'h0);
        put(27, "subw",  r_word(7'h20, 11, 0, f3_add, 28, op_32), 28, 64'hffff_ffff_8000_0000);
        put(28, "sllw",  r_word(7'h00, 12, 1, f3_sll, 29, op_32), 29, 64'h5000);
        put(29, "srlw",  r_word(7'h00, 1, 2, f3_sr, 30, op_32), 30, 64'h07ff_ffff);
        put(30, "sraw",  r_word(7'h20, 1, 2, f3_sr, 31, op_32), 31, 64'hffff_ffff_ffff_ffff);
        // dependent chain fetched with zero wait states
        put(31, "chain addi", i_word(12'd100, 0, f3_add, 1, op_imm), 1, 64'd100);
        put(32, "chain fwd", i_word(12'd1, 1, f3_add, 1, op_imm), 1, 64'd101);
        put(33, "chain add", r_word(7'h00, 1, 1, f3_add, 2, op), 2, 64'd202);
        put(34, "chain sub", r_word(7'h20, 1, 2, f3_add, 3, op), 3, 64'd101);
        put(35, "chain addw", r_word(7'h00, 2, 3, f3_add, 4, op_32), 4, 64'd303);
        put(36, "write x0", i_word(12'd7, 1, f3_add, 0, op_imm), 0, 64'h0);
        prog[37] = '{name: "unsupported", word: 32'hffff_ffff, retires: 1'b0, fast: 1'b1,
                     rd: 5'd0, value: 64'h0};
        put(38, "read x0", r_word(7'h00, 4, 0, f3_add, 5, op), 5, 64'd303);
    endtask

    // wishbone slave with 0 to 2 wait states
    always @(negedge c_clk) begin
        logic [63:0] idx;
        idx = ibus_o.adr >> 2;
        if (!c_rst_n || !ibus_o.cyc || !ibus_o.stb) begin
            ibus_i  <= '0;
            pending = 1'b0;
        end else begin
            if (!pending) begin
                wait_cnt = $unsigned($random(seed)) % 3;
                if (idx < n_entries && prog[idx].fast) begin
                    wait_cnt = 0;
                end
                pending = 1'b1;
            end
            if (wait_cnt == 0) begin
                ibus_i.ack <= 1'b1;
                ibus_i.dat <= (idx < n_entries) ? prog[idx].word : nop_word;
                pending = 1'b0;
            end else begin
                ibus_i.ack <= 1'b0;
                wait_cnt = wait_cnt - 1;
            end
        end
    end

    // failures of the bound assertions
    always @(negedge c_clk) begin
        if (u_dut.u_assertions.fail_cnt != 0) begin
            $display("a bus protocol or retire port assertion failed");
            $display("sim failed");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        repeat (limit_cycles + 4) @(posedge c_clk);
        $display("timeout: the retire stream stopped before the program was done");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        fill_program();
        repeat (4) begin
            @(negedge c_clk);
            check("reset cyc", 64'h0, ibus_o.cyc);
            check("reset stb", 64'h0, ibus_o.stb);
            check("reset retire", 64'h0, retire_o.valid);
        end
        c_rst_n = 1'b1;
        @(negedge c_clk);
        while (!ibus_o.cyc) begin
            @(negedge c_clk);
        end
        check("first adr", 64'h0, ibus_o.adr);

        for (int i = 0; i < n_entries; i++) begin
            if (prog[i].retires) begin
                while (!retire_o.valid) begin
                    @(negedge c_clk);
                end
                check($sformatf("%s pc", prog[i].name), 64'(i * 4), retire_o.pc);
                check($sformatf("%s rd", prog[i].name), prog[i].rd, retire_o.rd);
                check($sformatf("%s value", prog[i].name), prog[i].value, retire_o.value);
                @(negedge c_clk);
            end
        end

        // only bubbles past the end of the table
        repeat (10) begin
            @(negedge c_clk);
            check("retire past table", 64'h0, retire_o.valid);
        end
        if (u_dut.u_assertions.fail_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "assertion failure");
        end
    end

endmodule

// File: tb.f
src/rv_isa_pkg.sv
src/core_pkg.sv
src/fetch_unit.sv
src/decode_stage.sv
src/regfile.sv
src/alu.sv
src/execute_stage.sv
src/rv_core_top.sv
sim/rv_core_assertions.sv
sim/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - src/rv_isa_pkg.sv
  - src/core_pkg.sv
  - src/fetch_unit.sv
  - src/decode_stage.sv
  - src/regfile.sv
  - src/alu.sv
  - src/execute_stage.sv
  - src/rv_core_top.sv
  - target: simulation
    files:
      - sim/rv_core_assertions.sv
      - sim/tb_rv_core.sv
